//--- verilog/isa_pkg.sv
package isa_pkg;

    // Primary opcode field, instr[31:26].
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // Function field of SPECIAL instructions, instr[5:0].
    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_srl     = 6'h02;
    localparam logic [5:0] fn_sra     = 6'h03;
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_mfhi    = 6'h10;
    localparam logic [5:0] fn_mthi    = 6'h11;
    localparam logic [5:0] fn_mflo    = 6'h12;
    localparam logic [5:0] fn_mtlo    = 6'h13;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_slt     = 6'h2a;

    // Link register written by JAL.
    localparam logic [4:0] reg_ra = 5'd31;

    // One instruction word seen as R-format or as I-format.
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_u;

endpackage

//--- verilog/ctl_pkg.sv
package ctl_pkg;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
        alu_sll, alu_srl, alu_sra, alu_lui, alu_ncare
    } alu_funct_e;

    typedef enum logic [1:0] {
        src_a_rs, src_a_ncare
    } alu_src_a_e;

    typedef enum logic [1:0] {
        src_b_rt, src_b_sign_imm, src_b_zero_imm, src_b_ncare
    } alu_src_b_e;

    typedef enum logic [1:0] {
        src_sa_shamt, src_sa_ncare
    } alu_src_sa_e;

    typedef enum logic [1:0] {
        dest_rd, dest_rt, dest_ra, dest_ncare
    } dest_reg_e;

    // Next PC selection for the fetch stage.
    typedef enum logic [2:0] {
        pc_next, pc_branch, pc_jump, pc_register, pc_exception
    } pc_src_e;

    // Writeback data source.
    typedef enum logic [2:0] {
        reg_src_alu, reg_src_mem, reg_src_hi, reg_src_lo, reg_src_pc8, reg_src_ncare
    } reg_src_e;

    // Register operands read, used later by hazard logic.
    typedef enum logic [1:0] {
        opd_none, opd_rs, opd_rt, opd_both
    } opd_use_e;

    typedef enum logic [1:0] {
        exc_none, exc_syscall, exc_reserved
    } exc_chk_e;

    typedef struct packed {
        alu_funct_e  alu_funct;
        alu_src_a_e  alu_src_a;
        alu_src_b_e  alu_src_b;
        alu_src_sa_e alu_src_sa;
        dest_reg_e   dest_reg;
        pc_src_e     pc_src;
        reg_src_e    reg_src;
        opd_use_e    opd_use;
        exc_chk_e    exc_chk;
        logic        mem_read;
        logic        mem_write;
        logic        write_reg;
        logic        write_hi;
        logic        write_lo;
    } control_t;

    // Reserved instruction: trap, touch no state.
    localparam control_t ctl_reserved = '{
        alu_funct:  alu_ncare,
        alu_src_a:  src_a_ncare,
        alu_src_b:  src_b_ncare,
        alu_src_sa: src_sa_ncare,
        dest_reg:   dest_ncare,
        pc_src:     pc_exception,
        reg_src:    reg_src_ncare,
        opd_use:    opd_none,
        exc_chk:    exc_reserved,
        mem_read:   1'b0,
        mem_write:  1'b0,
        write_reg:  1'b0,
        write_hi:   1'b0,
        write_lo:   1'b0
    };

endpackage

//--- verilog/decode_bus_if.sv
`timescale 1ns/10ps

interface decode_bus_if;

    logic              valid;
    isa_pkg::instr_u   instr;
    ctl_pkg::control_t rtype_ctl;
    ctl_pkg::control_t main_ctl;

    modport rtype (
        input  instr,
        output rtype_ctl
    );

    modport main (
        input  instr,
        output main_ctl
    );

    modport merge (
        input  valid,
        input  instr,
        input  rtype_ctl,
        input  main_ctl
    );

endinterface

//--- verilog/rtype_decoder.sv
`timescale 1ns/10ps

module rtype_decoder (
    decode_bus_if.rtype bus
);

    // Common R-type shape: rs op rt into rd through the ALU.
    localparam ctl_pkg::control_t rtype_default = '{
        alu_funct:  ctl_pkg::alu_ncare,
        alu_src_a:  ctl_pkg::src_a_rs,
        alu_src_b:  ctl_pkg::src_b_rt,
        alu_src_sa: ctl_pkg::src_sa_ncare,
        dest_reg:   ctl_pkg::dest_rd,
        pc_src:     ctl_pkg::pc_next,
        reg_src:    ctl_pkg::reg_src_alu,
        opd_use:    ctl_pkg::opd_both,
        exc_chk:    ctl_pkg::exc_none,
        mem_read:   1'b0,
        mem_write:  1'b0,
        write_reg:  1'b1,
        write_hi:   1'b0,
        write_lo:   1'b0
    };

    ctl_pkg::control_t ctl;

    always_comb begin
        ctl = rtype_default;
        case (bus.instr.r.funct)
            isa_pkg::fn_sll, isa_pkg::fn_srl, isa_pkg::fn_sra: begin
                // Shift amount comes from shamt, only rt is read.
                ctl.alu_src_a  = ctl_pkg::src_a_ncare;
                ctl.alu_src_sa = ctl_pkg::src_sa_shamt;
                ctl.opd_use    = ctl_pkg::opd_rt;
                if (bus.instr.r.funct == isa_pkg::fn_sll) begin
                    ctl.alu_funct = ctl_pkg::alu_sll;
                end else if (bus.instr.r.funct == isa_pkg::fn_srl) begin
                    ctl.alu_funct = ctl_pkg::alu_srl;
                end else begin
                    ctl.alu_funct = ctl_pkg::alu_sra;
                end
            end
            isa_pkg::fn_addu: ctl.alu_funct = ctl_pkg::alu_add;
            isa_pkg::fn_subu: ctl.alu_funct = ctl_pkg::alu_sub;
            isa_pkg::fn_and:  ctl.alu_funct = ctl_pkg::alu_and;
            isa_pkg::fn_or:   ctl.alu_funct = ctl_pkg::alu_or;
            isa_pkg::fn_xor:  ctl.alu_funct = ctl_pkg::alu_xor;
            isa_pkg::fn_slt:  ctl.alu_funct = ctl_pkg::alu_slt;
            isa_pkg::fn_jr: begin
                ctl.alu_src_a = ctl_pkg::src_a_ncare;
                ctl.alu_src_b = ctl_pkg::src_b_ncare;
                ctl.dest_reg  = ctl_pkg::dest_ncare;
                ctl.pc_src    = ctl_pkg::pc_register;
                ctl.reg_src   = ctl_pkg::reg_src_ncare;
                ctl.opd_use   = ctl_pkg::opd_rs;
                ctl.write_reg = 1'b0;
            end
            isa_pkg::fn_mfhi, isa_pkg::fn_mflo: begin
                // No operand read, rd takes hi or lo.
                ctl.alu_src_a = ctl_pkg::src_a_ncare;
                ctl.alu_src_b = ctl_pkg::src_b_ncare;
                ctl.opd_use   = ctl_pkg::opd_none;
                ctl.reg_src   = (bus.instr.r.funct == isa_pkg::fn_mfhi) ?
                                ctl_pkg::reg_src_hi : ctl_pkg::reg_src_lo;
            end
            isa_pkg::fn_mthi, isa_pkg::fn_mtlo: begin
                ctl.alu_src_a = ctl_pkg::src_a_ncare;
                ctl.alu_src_b = ctl_pkg::src_b_ncare;
                ctl.dest_reg  = ctl_pkg::dest_ncare;
                ctl.reg_src   = ctl_pkg::reg_src_ncare;
                ctl.opd_use   = ctl_pkg::opd_rs;
                ctl.write_reg = 1'b0;
                ctl.write_hi  = (bus.instr.r.funct == isa_pkg::fn_mthi);
                ctl.write_lo  = (bus.instr.r.funct == isa_pkg::fn_mtlo);
            end
            isa_pkg::fn_syscall: begin
                ctl.alu_src_a = ctl_pkg::src_a_ncare;
                ctl.alu_src_b = ctl_pkg::src_b_ncare;
                ctl.dest_reg  = ctl_pkg::dest_ncare;
                ctl.pc_src    = ctl_pkg::pc_exception;
                ctl.reg_src   = ctl_pkg::reg_src_ncare;
                ctl.opd_use   = ctl_pkg::opd_none;
                ctl.exc_chk   = ctl_pkg::exc_syscall;
                ctl.write_reg = 1'b0;
            end
            default: ctl = ctl_pkg::ctl_reserved;
        endcase
    end

    assign bus.rtype_ctl = ctl;

endmodule

//--- verilog/opcode_decoder.sv
`timescale 1ns/10ps

module opcode_decoder (
    decode_bus_if.main bus
);

    // Immediate arithmetic shape: rs op imm into rt.
    localparam ctl_pkg::control_t imm_default = '{
        alu_funct:  ctl_pkg::alu_add,
        alu_src_a:  ctl_pkg::src_a_rs,
        alu_src_b:  ctl_pkg::src_b_sign_imm,
        alu_src_sa: ctl_pkg::src_sa_ncare,
        dest_reg:   ctl_pkg::dest_rt,
        pc_src:     ctl_pkg::pc_next,
        reg_src:    ctl_pkg::reg_src_alu,
        opd_use:    ctl_pkg::opd_rs,
        exc_chk:    ctl_pkg::exc_none,
        mem_read:   1'b0,
        mem_write:  1'b0,
        write_reg:  1'b1,
        write_hi:   1'b0,
        write_lo:   1'b0
    };

    ctl_pkg::control_t ctl;

    always_comb begin
        ctl = imm_default;
        case (bus.instr.i.opcode)
            isa_pkg::op_addiu: ctl.alu_funct = ctl_pkg::alu_add;
            isa_pkg::op_andi: begin
                ctl.alu_funct = ctl_pkg::alu_and;
                ctl.alu_src_b = ctl_pkg::src_b_zero_imm;
            end
            isa_pkg::op_ori: begin
                ctl.alu_funct = ctl_pkg::alu_or;
                ctl.alu_src_b = ctl_pkg::src_b_zero_imm;
            end
            isa_pkg::op_lui: begin
                ctl.alu_funct = ctl_pkg::alu_lui;
                ctl.alu_src_a = ctl_pkg::src_a_ncare;
                ctl.alu_src_b = ctl_pkg::src_b_zero_imm;
                ctl.opd_use   = ctl_pkg::opd_none;
            end
            isa_pkg::op_lw: begin
                ctl.mem_read = 1'b1;
                ctl.reg_src  = ctl_pkg::reg_src_mem;
            end
            isa_pkg::op_sw: begin
                // Address from rs plus offset, store data from rt.
                ctl.mem_write = 1'b1;
                ctl.write_reg = 1'b0;
                ctl.dest_reg  = ctl_pkg::dest_ncare;
                ctl.reg_src   = ctl_pkg::reg_src_ncare;
                ctl.opd_use   = ctl_pkg::opd_both;
            end
            isa_pkg::op_beq, isa_pkg::op_bne: begin
                ctl.alu_funct = ctl_pkg::alu_sub;
                ctl.alu_src_b = ctl_pkg::src_b_rt;
                ctl.pc_src    = ctl_pkg::pc_branch;
                ctl.dest_reg  = ctl_pkg::dest_ncare;
                ctl.reg_src   = ctl_pkg::reg_src_ncare;
                ctl.opd_use   = ctl_pkg::opd_both;
                ctl.write_reg = 1'b0;
            end
            isa_pkg::op_j, isa_pkg::op_jal: begin
                ctl.alu_funct = ctl_pkg::alu_ncare;
                ctl.alu_src_a = ctl_pkg::src_a_ncare;
                ctl.alu_src_b = ctl_pkg::src_b_ncare;
                ctl.pc_src    = ctl_pkg::pc_jump;
                ctl.opd_use   = ctl_pkg::opd_none;
                // JAL links the return address, pc+8, into $ra.
                ctl.write_reg = (bus.instr.i.opcode == isa_pkg::op_jal);
                ctl.dest_reg  = ctl.write_reg ? ctl_pkg::dest_ra : ctl_pkg::dest_ncare;
                ctl.reg_src   = ctl.write_reg ? ctl_pkg::reg_src_pc8 : ctl_pkg::reg_src_ncare;
            end
            default: ctl = ctl_pkg::ctl_reserved;
        endcase
    end

    assign bus.main_ctl = ctl;

endmodule

//--- verilog/control_merge.sv
`timescale 1ns/10ps

module control_merge (
    input  logic               clk,
    input  logic               rst,
    decode_bus_if.merge        bus,
    output logic               out_valid,
    output ctl_pkg::control_t  ctl,
    output logic [4:0]         dest_index
);

    ctl_pkg::control_t sel_ctl;
    logic [4:0]        sel_dest;

    // SPECIAL goes to the funct decoder, everything else to the opcode decoder.
    assign sel_ctl = (bus.instr.i.opcode == isa_pkg::op_special) ?
                     bus.rtype_ctl : bus.main_ctl;

    always_comb begin
        case (sel_ctl.dest_reg)
            ctl_pkg::dest_rd: sel_dest = bus.instr.r.rd;
            ctl_pkg::dest_rt: sel_dest = bus.instr.r.rt;
            ctl_pkg::dest_ra: sel_dest = isa_pkg::reg_ra;
            default:          sel_dest = 5'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid     <= 1'b0;
            ctl.mem_read  <= 1'b0;
            ctl.mem_write <= 1'b0;
            ctl.write_reg <= 1'b0;
            ctl.write_hi  <= 1'b0;
            ctl.write_lo  <= 1'b0;
        end else begin
            out_valid <= bus.valid;
            // Hold the previous word across idle cycles.
            if (bus.valid) begin
                ctl        <= sel_ctl;
                dest_index <= sel_dest;
            end
        end
    end

    a_reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid);

    // Neither decoder may pair a register write with a trap.
    a_no_write_on_exc: assert property (@(posedge clk) disable iff (rst)
        !(ctl.write_reg && ctl.exc_chk != ctl_pkg::exc_none));

    a_mem_onehot: assert property (@(posedge clk) disable iff (rst)
        !(ctl.mem_read && ctl.mem_write));

endmodule

//--- verilog/decode_top.sv
`timescale 1ns/10ps

module decode_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic [31:0]          instruction,
    output logic                 out_valid,
    output ctl_pkg::alu_funct_e  alu_funct,
    output ctl_pkg::alu_src_a_e  alu_src_a,
    output ctl_pkg::alu_src_b_e  alu_src_b,
    output ctl_pkg::alu_src_sa_e alu_src_sa,
    output logic [4:0]           dest_index,
    output ctl_pkg::pc_src_e     pc_src,
    output ctl_pkg::reg_src_e    reg_src,
    output ctl_pkg::opd_use_e    opd_use,
    output ctl_pkg::exc_chk_e    exc_chk,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic                 write_reg,
    output logic                 write_hi,
    output logic                 write_lo
);

    ctl_pkg::control_t ctl;

    decode_bus_if bus ();

    assign bus.valid = in_valid;
    assign bus.instr = instruction;

    rtype_decoder  u_rtype  (.bus(bus.rtype));
    opcode_decoder u_opcode (.bus(bus.main));

    control_merge u_merge (
        .clk        (clk),
        .rst        (rst),
        .bus        (bus.merge),
        .out_valid  (out_valid),
        .ctl        (ctl),
        .dest_index (dest_index)
    );

    // Registered control word onto the execute-stage ports.
    assign alu_funct  = ctl.alu_funct;
    assign alu_src_a  = ctl.alu_src_a;
    assign alu_src_b  = ctl.alu_src_b;
    assign alu_src_sa = ctl.alu_src_sa;
    assign pc_src     = ctl.pc_src;
    assign reg_src    = ctl.reg_src;
    assign opd_use    = ctl.opd_use;
    assign exc_chk    = ctl.exc_chk;
    assign mem_read   = ctl.mem_read;
    assign mem_write  = ctl.mem_write;
    assign write_reg  = ctl.write_reg;
    assign write_hi   = ctl.write_hi;
    assign write_lo   = ctl.write_lo;

endmodule

//--- test/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

typedef struct packed {
    logic       valid;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic [3:0] alu_funct;
    logic [1:0] alu_src_a;
    logic [1:0] alu_src_b;
    logic [1:0] alu_src_sa;
    logic [1:0] dest;
    logic [2:0] pc_src;
    logic [2:0] reg_src;
    logic [1:0] opd_use;
    logic [1:0] exc_chk;
    logic [4:0] enables;
} vector_t;

localparam int num_rows = 30;

// Columns: in_valid, opcode, funct, then expected alu_funct, alu_src_a, alu_src_b, alu_src_sa,
// dest (0 rd, 1 rt, 2 ra, 3 none), pc_src, reg_src, opd_use, exc_chk, {mr, mw, wr, hi, lo}.
// Rows with in_valid low expect the word held from the row before.
vector_t vectors [num_rows] = '{
    '{1'b1, 6'h00, 6'h00, 4'd6,  2'd1, 2'd0, 2'd0, 2'd0, 3'd0, 3'd0, 2'd2, 2'd0, 5'b00100},
    '{1'b1, 6'h00, 6'h02, 4'd7,  2'd1, 2'd0, 2'd0, 2'd0, 3'd0, 3'd0, 2'd2, 2'd0, 5'b00100},
    '{1'b1, 6'h00, 6'h03, 4'd8,  2'd1, 2'd0, 2'd0, 2'd0, 3'd0, 3'd0, 2'd2, 2'd0, 5'b00100},
    '{1'b1, 6'h00, 6'h21, 4'd0,  2'd0, 2'd0, 2'd1, 2'd0, 3'd0, 3'd0, 2'd3, 2'd0, 5'b00100},
    '{1'b1, 6'h00, 6'h23, 4'd1,  2'd0, 2'd0, 2'd1, 2'd0, 3'd0, 3'd0, 2'd3, 2'd0, 5'b00100},
    '{1'b1, 6'h00, 6'h24, 4'd2,  2'd0, 2'd0, 2'd1, 2'd0, 3'd0, 3'd0, 2'd3, 2'd0, 5'b00100},
    '{1'b0, 6'h00, 6'h21, 4'd2,  2'd0, 2'd0, 2'd1, 2'd0, 3'd0, 3'd0, 2'd3, 2'd0, 5'b00100},
    '{1'b1, 6'h00, 6'h25, 4'd3,  2'd0, 2'd0, 2'd1, 2'd0, 3'd0, 3'd0, 2'd3, 2'd0, 5'b00100},
    '{1'b1, 6'h00, 6'h26, 4'd4,  2'd0, 2'd0, 2'd1, 2'd0, 3'd0, 3'd0, 2'd3, 2'd0, 5'b00100},
    '{1'b1, 6'h00, 6'h2a, 4'd5,  2'd0, 2'd0, 2'd1, 2'd0, 3'd0, 3'd0, 2'd3, 2'd0, 5'b00100},
    '{1'b1, 6'h00, 6'h08, 4'd10, 2'd1, 2'd3, 2'd1, 2'd3, 3'd3, 3'd5, 2'd1, 2'd0, 5'b00000},
    '{1'b1, 6'h00, 6'h10, 4'd10, 2'd1, 2'd3, 2'd1, 2'd0, 3'd0, 3'd2, 2'd0, 2'd0, 5'b00100},
    '{1'b1, 6'h00, 6'h12, 4'd10, 2'd1, 2'd3, 2'd1, 2'd0, 3'd0, 3'd3, 2'd0, 2'd0, 5'b00100},
    '{1'b1, 6'h00, 6'h11, 4'd10, 2'd1, 2'd3, 2'd1, 2'd3, 3'd0, 3'd5, 2'd1, 2'd0, 5'b00010},
    '{1'b1, 6'h00, 6'h13, 4'd10, 2'd1, 2'd3, 2'd1, 2'd3, 3'd0, 3'd5, 2'd1, 2'd0, 5'b00001},
    '{1'b1, 6'h00, 6'h0c, 4'd10, 2'd1, 2'd3, 2'd1, 2'd3, 3'd4, 3'd5, 2'd0, 2'd1, 5'b00000},
    '{1'b0, 6'h00, 6'h0c, 4'd10, 2'd1, 2'd3, 2'd1, 2'd3, 3'd4, 3'd5, 2'd0, 2'd1, 5'b00000},
    '{1'b1, 6'h00, 6'h3f, 4'd10, 2'd1, 2'd3, 2'd1, 2'd3, 3'd4, 3'd5, 2'd0, 2'd2, 5'b00000},
    // Opcode formats. Low bits hold funct-like values that must not matter.
    '{1'b1, 6'h09, 6'h08, 4'd0,  2'd0, 2'd1, 2'd1, 2'd1, 3'd0, 3'd0, 2'd1, 2'd0, 5'b00100},
    '{1'b1, 6'h0c, 6'h0c, 4'd2,  2'd0, 2'd2, 2'd1, 2'd1, 3'd0, 3'd0, 2'd1, 2'd0, 5'b00100},
    '{1'b1, 6'h0d, 6'h21, 4'd3,  2'd0, 2'd2, 2'd1, 2'd1, 3'd0, 3'd0, 2'd1, 2'd0, 5'b00100},
    '{1'b1, 6'h0f, 6'h3f, 4'd9,  2'd1, 2'd2, 2'd1, 2'd1, 3'd0, 3'd0, 2'd0, 2'd0, 5'b00100},
    '{1'b1, 6'h23, 6'h10, 4'd0,  2'd0, 2'd1, 2'd1, 2'd1, 3'd0, 3'd1, 2'd1, 2'd0, 5'b10100},
    '{1'b1, 6'h2b, 6'h11, 4'd0,  2'd0, 2'd1, 2'd1, 2'd3, 3'd0, 3'd5, 2'd3, 2'd0, 5'b01000},
    '{1'b1, 6'h04, 6'h00, 4'd1,  2'd0, 2'd0, 2'd1, 2'd3, 3'd1, 3'd5, 2'd3, 2'd0, 5'b00000},
    '{1'b1, 6'h05, 6'h2a, 4'd1,  2'd0, 2'd0, 2'd1, 2'd3, 3'd1, 3'd5, 2'd3, 2'd0, 5'b00000},
    '{1'b1, 6'h02, 6'h13, 4'd10, 2'd1, 2'd3, 2'd1, 2'd3, 3'd2, 3'd5, 2'd0, 2'd0, 5'b00000},
    '{1'b1, 6'h03, 6'h12, 4'd10, 2'd1, 2'd3, 2'd1, 2'd2, 3'd2, 3'd4, 2'd0, 2'd0, 5'b00100},
    '{1'b0, 6'h03, 6'h12, 4'd10, 2'd1, 2'd3, 2'd1, 2'd2, 3'd2, 3'd4, 2'd0, 2'd0, 5'b00100},
    '{1'b1, 6'h3f, 6'h21, 4'd10, 2'd1, 2'd3, 2'd1, 2'd3, 3'd4, 3'd5, 2'd0, 2'd2, 5'b00000}
};

`endif

//--- test/decode_tb.sv
`timescale 1ns/10ps

module decode_tb;

    `include "decode_vectors.svh"

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    logic [31:0]          instruction;
    logic                 out_valid;
    ctl_pkg::alu_funct_e  alu_funct;
    ctl_pkg::alu_src_a_e  alu_src_a;
    ctl_pkg::alu_src_b_e  alu_src_b;
    ctl_pkg::alu_src_sa_e alu_src_sa;
    ctl_pkg::pc_src_e     pc_src;
    ctl_pkg::reg_src_e    reg_src;
    ctl_pkg::opd_use_e    opd_use;
    ctl_pkg::exc_chk_e    exc_chk;
    logic [4:0]           dest_index;
    logic                 mem_read, mem_write, write_reg, write_hi, write_lo;

    logic [31:0] lfsr_state = 32'h8036_5df3;
    logic [4:0]  row_rd [num_rows];
    logic [4:0]  row_rt [num_rows];
    int          cycles = 0;

    decode_top u_decode_top (.*);

    always #10 clk = ~clk;

    // Reset, every row and one drain cycle fit well inside this limit.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= num_rows + 20) begin
            $display("Timeout: the run did not finish within %0d cycles", num_rows + 20);
            $display("*** FAILED ***");
            $fatal(1, "simulation timed out");
        end
    end

    // Fibonacci LFSR, taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [4:0] random_reg();
        logic [4:0] v;
        v = '0;
        for (int b = 0; b < 5; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[3:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
                     $time, what, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Registered outputs of row i, one cycle after it was presented.
    // An idle row expects the control word of the row before it.
    task automatic check_row(input int i);
        vector_t    v;
        logic [4:0] exp_dest;
        v = vectors[i];
        exp_dest = (v.dest == 2'd0) ? row_rd[i] : (v.dest == 2'd1) ? row_rt[i] : 5'd31;
        check_value($sformatf("row %0d out_valid", i), 32'(out_valid), 32'(v.valid));
        check_value($sformatf("row %0d alu_funct", i), 32'(alu_funct), 32'(v.alu_funct));
        check_value($sformatf("row %0d alu_src_a", i), 32'(alu_src_a), 32'(v.alu_src_a));
        check_value($sformatf("row %0d alu_src_b", i), 32'(alu_src_b), 32'(v.alu_src_b));
        check_value($sformatf("row %0d alu_src_sa", i), 32'(alu_src_sa), 32'(v.alu_src_sa));
        check_value($sformatf("row %0d pc_src", i), 32'(pc_src), 32'(v.pc_src));
        check_value($sformatf("row %0d reg_src", i), 32'(reg_src), 32'(v.reg_src));
        check_value($sformatf("row %0d opd_use", i), 32'(opd_use), 32'(v.opd_use));
        check_value($sformatf("row %0d exc_chk", i), 32'(exc_chk), 32'(v.exc_chk));
        check_value($sformatf("row %0d enables", i),
                    32'({mem_read, mem_write, write_reg, write_hi, write_lo}),
                    32'(v.enables));
        // The destination only matters when a register is written.
        if (v.valid && v.enables[2]) begin
            check_value($sformatf("row %0d dest_index", i), 32'(dest_index),
                        32'(exp_dest));
        end
    endtask

    initial begin
        logic [4:0] rs;
        logic [4:0] shamt;
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        instruction = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("out_valid after reset", 32'(out_valid), 32'd0);
        check_value("enables after reset",
                    32'({mem_read, mem_write, write_reg, write_hi, write_lo}), 32'd0);
        for (int i = 0; i <= num_rows; i++) begin
            @(posedge clk);
            #1;
            if (i > 0) begin
                check_row(i - 1);
            end
            if (i < num_rows) begin
                rs = random_reg();
                row_rt[i] = random_reg();
                row_rd[i] = random_reg();
                shamt = random_reg();
                instruction = {vectors[i].opcode, rs, row_rt[i], row_rd[i], shamt,
                               vectors[i].funct};
                in_valid = vectors[i].valid;
            end else begin
                in_valid = 1'b0;
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- project.f
+incdir+test
verilog/isa_pkg.sv
verilog/ctl_pkg.sv
verilog/decode_bus_if.sv
verilog/rtype_decoder.sv
verilog/opcode_decoder.sv
verilog/control_merge.sv
verilog/decode_top.sv
test/decode_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = decode_tb
FILELIST  = project.f
BUILD_DIR = build
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
